// File: compile.f
src/rvCorePkg.sv
src/instrDecode.sv
src/regFile.sv
src/aluUnit.sv
src/fetchUnit.sv
src/rvCore.sv
bench/rvCoreMem.sv
bench/rvCore_props.sv
bench/rvCoreTb.sv

// File: bench/rvCoreTb.sv
// Directed testbench for the RV32I core with program builders, reference model and checks
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb;

    import rvCorePkg::*;

    localparam logic [31:0] bootAddr    = 32'h0000_1000;
    localparam int          haltTimeout = 400;

    logic        clock;
    logic        rst;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic        dataWe;
    logic        dataRe;
    logic [31:0] dataRdata;
    logic        illegal;

    // Bookkeeping for the program under construction
    integer      seed;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          testStart;
    int          progLen;
    int          slots;
    int          haltAt;
    logic [31:0] expected [0:63];

    rvCore #(.resetVector(bootAddr)) dut0 (.*);
    rvCoreMem #(.baseAddr(bootAddr)) mem0 (.*);

    bind rvCore rvCore_props props0 (
        .clock(clock), .rst(rst), .instrAddr(instrAddr), .dataWe(dataWe),
        .dataRe(dataRe), .illegal(illegal)
    );

    always #50 clock = ~clock;

    // Instruction encoders, one per format
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] upper, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {upper, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    // RV32I result for OP and OP-IMM, alt is instruction bit 30
    function automatic logic [31:0] refOp(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? (a - b) : (a + b);
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5:
            begin
                if (alt)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // Branch outcome by funct3
    function automatic logic refTaken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        checkCount++;
        if (got !== want)
        begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
            errorCount++;
        end
    endtask

    task emit(input logic [31:0] word);
        mem0.loadWord(progLen, word);
        progLen++;
    endtask

    // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
    task loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h0000_0800;
        emit(encU(upper[31:12], rd, opLui));
        emit(encI(value[11:0], rd, 3'b000, rd, opImm));
    endtask

    // SW rs to the next free data word, remembering what should land there
    task storeSlot(input logic [4:0] rs, input logic [31:0] value);
        logic [11:0] off;
        off = 4 * slots;
        emit({off[11:5], rs, 5'd0, 3'b010, off[4:0], opStore});
        expected[slots] = value;
        slots++;
    endtask

    // Inputs change a little after the rising edge
    task stepClock;
        @(posedge clock);
        #1;
    endtask

    task resetCore;
        rst = 1'b1;
        for (int c = 0; c < 16; c++)
        begin
            stepClock();
            checkValue("instrAddr", instrAddr, bootAddr);
            checkValue("dataWe", {31'd0, dataWe}, 32'd0);
        end
        rst = 1'b0;
        checkValue("instrAddr", instrAddr, bootAddr);
    endtask

    task waitHalt;
        int cycles;
        cycles = 0;
        while (!illegal && cycles < haltTimeout)
        begin
            stepClock();
            cycles++;
        end
        if (!illegal)
        begin
            $display("Timeout: core did not stop on an illegal word within %0d cycles", cycles);
            errorCount++;
        end
    endtask

    task startTest;
        mem0.clearAll();
        progLen   = 0;
        slots     = 0;
        haltAt    = -1;
        testStart = errorCount;
    endtask

    // Terminate, run to the stop, then check PC hold and every stored word
    task runProgram(input string name);
        if (haltAt < 0)
            haltAt = progLen;
        emit(32'h0000_0000);
        resetCore();
        waitHalt();
        repeat (3) stepClock();
        checkValue("instrAddr", instrAddr, bootAddr + 4 * haltAt);
        checkValue("illegal", {31'd0, illegal}, 32'd1);
        for (int k = 0; k < slots; k++)
            checkValue($sformatf("dmem[%0d]", k), mem0.readData(k), expected[k]);
        testCount++;
        $display("Test %0d %s: %s", testCount, name,
                 (errorCount == testStart) ? "passed" : "failed");
    endtask

    task testArith;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        logic [11:0] imm;
        logic        alt;
        startTest();
        a = $random(seed);
        b = $random(seed);
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        for (int f = 0; f < 8; f++)
        begin
            for (int s = 0; s < 2; s++)
            begin
                alt = s[0];
                // Bit 30 exists only on SUB, SRA and SRAI
                if (!alt || f == 0 || f == 5)
                begin
                    emit(encR(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f[2:0], 5'd3));
                    storeSlot(5'd3, refOp(f[2:0], alt, a, b));
                end
                if (!alt || f == 5)
                begin
                    rnd = $random(seed);
                    imm = rnd[11:0];
                    if (f == 1 || f == 5)
                        imm = {1'b0, alt, 5'b00000, rnd[4:0]};
                    emit(encI(imm, 5'd1, f[2:0], 5'd4, opImm));
                    storeSlot(5'd4, refOp(f[2:0], alt, a, {{20{imm[11]}}, imm}));
                end
            end
        end
        runProgram("arithmetic");
    endtask

    task testUpperMem;
        logic [31:0] rnd;
        logic [31:0] value;
        logic [31:0] pcAuipc;
        startTest();
        rnd = $random(seed);
        emit(encU(rnd[19:0], 5'd4, opLui));
        storeSlot(5'd4, {rnd[19:0], 12'h000});
        pcAuipc = bootAddr + 4 * progLen;
        emit(encU(rnd[19:0], 5'd5, opAuipc));
        storeSlot(5'd5, pcAuipc + {rnd[19:0], 12'h000});
        // Store, load back into another register, store again
        value = $random(seed);
        loadConst(5'd6, value);
        storeSlot(5'd6, value);
        emit(encI(4 * (slots - 1), 5'd0, 3'b010, 5'd7, opLoad));
        storeSlot(5'd7, value);
        runProgram("upper immediates and memory");
    endtask

    task testControl;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] marker;
        logic [31:0] linkBase;
        startTest();
        a      = $random(seed);
        b      = $random(seed);
        marker = $random(seed) | 32'd1;
        if (a == b)
            b = ~a;
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        loadConst(5'd8, marker);
        // Pairs (x1,x2), (x2,x1), (x1,x1) give both outcomes for every type
        for (int f = 0; f < 8; f++)
        begin
            if (f != 2 && f != 3)
            begin
                emit(encB(f[2:0], 5'd1, 5'd2, 13'd8));
                storeSlot(5'd8, refTaken(f[2:0], a, b) ? 32'd0 : marker);
                emit(encB(f[2:0], 5'd2, 5'd1, 13'd8));
                storeSlot(5'd8, refTaken(f[2:0], b, a) ? 32'd0 : marker);
                emit(encB(f[2:0], 5'd1, 5'd1, 13'd8));
                storeSlot(5'd8, refTaken(f[2:0], a, a) ? 32'd0 : marker);
            end
        end
        // JAL over a marker store
        linkBase = bootAddr + 4 * progLen;
        emit(encJ(5'd9, 21'd8));
        storeSlot(5'd8, 32'd0);
        storeSlot(5'd9, linkBase + 32'd4);
        // JALR from an AUIPC base, also over a marker store
        linkBase = bootAddr + 4 * progLen;
        emit(encU(20'd0, 5'd10, opAuipc));
        emit(encI(12'd12, 5'd10, 3'b000, 5'd11, opJalr));
        storeSlot(5'd8, 32'd0);
        storeSlot(5'd11, linkBase + 32'd8);
        runProgram("control flow");
    endtask

    task testZeroReg;
        logic [31:0] value;
        startTest();
        value = $random(seed);
        loadConst(5'd1, value);
        emit(encR(7'b0000000, 5'd1, 5'd1, 3'b000, 5'd0));
        emit(encI(12'h123, 5'd1, 3'b000, 5'd0, opImm));
        emit(encU(value[31:12], 5'd0, opLui));
        storeSlot(5'd0, 32'd0);
        runProgram("register x0");
    endtask

    task testIllegalStop;
        logic [31:0] value;
        startTest();
        value = $random(seed);
        loadConst(5'd1, value);
        storeSlot(5'd1, value);
        // ECALL, the store behind it must never happen
        haltAt = progLen;
        emit(32'h0000_0073);
        storeSlot(5'd1, 32'd0);
        runProgram("illegal stop");
    endtask

    initial
    begin
        seed       = 39371;
        errorCount = 0;
        checkCount = 0;
        testCount  = 0;
        clock      = 1'b0;
        rst        = 1'b1;
        startTest();
        resetCore();
        // Empty memory covers the reset behavior
        startTest();
        runProgram("reset");
        testArith();
        testUpperMem();
        testControl();
        testZeroReg();
        testIllegalStop();
        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
                 errorCount);
        if (errorCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/rvCore_props.sv
// Bound assertions on the core data port and the illegal-instruction stop
`timescale 1ns/10ps
`default_nettype none

module rvCore_props (
    input wire logic        clock,
    input wire logic        rst,
    input wire logic [31:0] instrAddr,
    input wire logic        dataWe,
    input wire logic        dataRe,
    input wire logic        illegal
);

    // One word is a load or a store, never both
    weNotRe: assert property (@(posedge clock) disable iff (rst) !(dataWe && dataRe))
        else $error("dataWe and dataRe high in the same cycle");

    // Undecoded words must not touch memory
    noWriteOnIllegal: assert property (@(posedge clock) disable iff (rst) illegal |-> !dataWe)
        else $error("dataWe high while illegal is high");

    // Stopped core keeps its PC
    pcHeld: assert property (@(posedge clock) disable iff (rst) illegal |=> $stable(instrAddr))
        else $error("instrAddr moved on the cycle after illegal");

endmodule

`default_nettype wire

// File: bench/rvCoreMem.sv
// Testbench memory model with instruction and data arrays, loader tasks and clocked data writes
`timescale 1ns/10ps
`default_nettype none

module rvCoreMem #(
    parameter logic [31:0] baseAddr = 32'h0000_0000
) (
    input  wire logic        clock,
    input  wire logic [31:0] instrAddr,
    output logic      [31:0] instr,
    input  wire logic [31:0] dataAddr,
    input  wire logic [31:0] dataWdata,
    input  wire logic        dataWe,
    input  wire logic        dataRe,
    output logic      [31:0] dataRdata
);

    // 256 words each, word addressed
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] instrOffset;

    // Instruction space starts at the core reset vector
    assign instrOffset = instrAddr - baseAddr;
    assign instr       = imem[instrOffset[9:2]];

    // Read data only while the core requests a load
    assign dataRdata   = dataRe ? dmem[dataAddr[9:2]] : 32'h0000_0000;

    always @(posedge clock)
    begin
        if (dataWe)
        begin
            dmem[dataAddr[9:2]] <= dataWdata;
        end
    end

    // Zero word decodes as illegal, so a cleared array stops the core
    task clearAll;
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = 32'h0000_0000;
            dmem[i] = 32'h0000_0000;
        end
    endtask

    task loadWord(input int index, input logic [31:0] word);
        imem[index] = word;
    endtask

    function automatic logic [31:0] readData(input int index);
        return dmem[index];
    endfunction

endmodule

`default_nettype wire

// File: src/rvCore.sv
// Single-cycle RV32I core top with operand muxing, write-back select and data port
`timescale 1ns/10ps
`default_nettype none

module rvCore #(
    parameter logic [31:0] resetVector = rvCorePkg::resetVectorDefault
) (
    input  wire logic        clock,
    input  wire logic        rst,
    output logic      [31:0] instrAddr,
    input  wire logic [31:0] instr,
    output logic      [31:0] dataAddr,
    output logic      [31:0] dataWdata,
    output logic             dataWe,
    output logic             dataRe,
    input  wire logic [31:0] dataRdata,
    output logic             illegal
);

    import rvCorePkg::*;

    decodedT     dec;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluResult;
    logic [31:0] wbData;
    logic        branchTaken;
    logic        regWe;

    fetchUnit #(.resetVector(resetVector)) fetch0 (
        .clock(clock), .rst(rst), .ctrl(dec.ctrl), .illegal(dec.illegal),
        .branchTaken(branchTaken), .imm(dec.imm), .jumpTarget(aluResult), .pc(pc)
    );

    instrDecode decode0 (.instr(instr), .dec(dec));

    regFile regs0 (
        .clock(clock), .rst(rst), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .writeEnable(regWe), .writeData(wbData), .rdata1(rdata1), .rdata2(rdata2)
    );

    aluUnit alu0 (
        .opA(opA), .opB(opB), .aluOp(dec.aluOp), .funct3(dec.funct3),
        .result(aluResult), .branchTaken(branchTaken)
    );

    // Operand select
    assign opA     = dec.ctrl.aluSrcPc ? pc : rdata1;
    assign opB     = dec.ctrl.aluSrcImm ? dec.imm : rdata2;
    assign pcPlus4 = pc + 32'd4;

    // Write-back source, link address for jumps
    always_comb
    begin
        case (dec.ctrl.wbSel)
            wbMem:   wbData = dataRdata;
            wbPc4:   wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // No register or memory side effects from an undecoded word
    assign regWe     = dec.ctrl.regWrite && !dec.illegal;
    assign dataWe    = dec.ctrl.memWrite && !dec.illegal;
    assign dataRe    = dec.ctrl.memRead && !dec.illegal;
    assign dataAddr  = aluResult;
    assign dataWdata = rdata2;
    assign instrAddr = pc;
    assign illegal   = dec.illegal;

endmodule

`default_nettype wire

// File: src/fetchUnit.sv
// PC register with reset vector, next-PC selection and halt on illegal instruction
`timescale 1ns/10ps
`default_nettype none

module fetchUnit #(
    parameter logic [31:0] resetVector = rvCorePkg::resetVectorDefault
) (
    input  wire logic        clock,
    input  wire logic        rst,
    input  rvCorePkg::ctrlT  ctrl,
    input  wire logic        illegal,
    input  wire logic        branchTaken,
    input  wire logic [31:0] imm,
    input  wire logic [31:0] jumpTarget,
    output logic      [31:0] pc
);

    logic [31:0] nextPc;
    logic        takeRelative;

    // JAL or a taken branch both go PC relative
    assign takeRelative = ctrl.jump || (ctrl.branch && branchTaken);

    always_comb
    begin
        if (ctrl.jumpReg)
        begin
            // JALR target with bit 0 cleared
            nextPc = {jumpTarget[31:1], 1'b0};
        end
        else if (takeRelative)
        begin
            nextPc = pc + imm;
        end
        else
        begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc <= resetVector;
        end
        else if (!illegal)
        begin
            // Hold here forever once an undecoded word shows up
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: src/aluUnit.sv
// Combinational RV32I ALU with branch condition evaluation
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
    input  wire logic [31:0]   opA,
    input  wire logic [31:0]   opB,
    input  rvCorePkg::aluOpT   aluOp,
    input  wire logic [2:0]    funct3,
    output logic      [31:0]   result,
    output logic               branchTaken
);

    import rvCorePkg::*;

    // Shift amount is the low five bits of operand B
    logic [4:0] shamt;
    logic       isEqual;
    logic       isLess;
    logic       isLessU;

    assign shamt   = opB[4:0];
    assign isEqual = (opA == opB);
    assign isLess  = ($signed(opA) < $signed(opB));
    assign isLessU = (opA < opB);

    always_comb
    begin
        case (aluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluSll:   result = opA << shamt;
            aluSlt:   result = {31'd0, isLess};
            aluSltu:  result = {31'd0, isLessU};
            aluXor:   result = opA ^ opB;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = $unsigned($signed(opA) >>> shamt);
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluPassB: result = opB;
            default:  result = 32'h0000_0000;
        endcase
    end

    // Branch condition by funct3
    // Only meaningful while a branch is decoded
    always_comb
    begin
        case (funct3)
            3'b000:  branchTaken = isEqual;    // BEQ
            3'b001:  branchTaken = !isEqual;   // BNE
            3'b100:  branchTaken = isLess;     // BLT
            3'b101:  branchTaken = !isLess;    // BGE
            3'b110:  branchTaken = isLessU;    // BLTU
            3'b111:  branchTaken = !isLessU;   // BGEU
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/regFile.sv
// Register file of 32 x 32 bits, two read ports, one write port, x0 tied to zero
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire logic        clock,
    input  wire logic        rst,
    input  wire logic [4:0]  rs1,
    input  wire logic [4:0]  rs2,
    input  wire logic [4:0]  rd,
    input  wire logic        writeEnable,
    input  wire logic [31:0] writeData,
    output logic      [31:0] rdata1,
    output logic      [31:0] rdata2
);

    // Only x1..x31 have storage
    logic [31:0] regs [31:1];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= 32'h0000_0000;
            end
        end
        else if (writeEnable && (rd != 5'd0))
        begin
            // Writes to x0 fall through here and are lost
            regs[rd] <= writeData;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rdata1 = (rs1 == 5'd0) ? 32'h0000_0000 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'h0000_0000 : regs[rs2];

endmodule

`default_nettype wire

// File: src/instrDecode.sv
// RV32I instruction decoder with immediate generation, control setup and illegal detection
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
    input  wire logic [31:0]        instr,
    output rvCorePkg::decodedT      dec
);

    import rvCorePkg::*;

    // Raw instruction fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    // Immediates for each format
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // Decode results before packing
    logic [31:0] immValue;
    aluOpT       aluOpSel;
    ctrlT        ctrlBits;
    logic        isIllegal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign bit is always instr[31]
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'h000};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        // Defaults, overridden per opcode
        ctrlBits  = '0;
        aluOpSel  = aluAdd;
        immValue  = immI;
        isIllegal = 1'b0;

        case (opcode)
            opLui:
            begin
                immValue           = immU;
                aluOpSel           = aluPassB;
                ctrlBits.regWrite  = 1'b1;
                ctrlBits.aluSrcImm = 1'b1;
            end
            opAuipc:
            begin
                // PC plus upper immediate
                immValue           = immU;
                ctrlBits.regWrite  = 1'b1;
                ctrlBits.aluSrcImm = 1'b1;
                ctrlBits.aluSrcPc  = 1'b1;
            end
            opJal:
            begin
                immValue          = immJ;
                ctrlBits.regWrite = 1'b1;
                ctrlBits.jump     = 1'b1;
                ctrlBits.wbSel    = wbPc4;
            end
            opJalr:
            begin
                // Target is rs1 plus imm, computed in the ALU
                ctrlBits.regWrite  = 1'b1;
                ctrlBits.jumpReg   = 1'b1;
                ctrlBits.aluSrcImm = 1'b1;
                ctrlBits.wbSel     = wbPc4;
                isIllegal          = (funct3 != 3'b000);
            end
            opBranch:
            begin
                immValue        = immB;
                aluOpSel        = aluSub;
                ctrlBits.branch = 1'b1;
                // funct3 010 and 011 are not branches
                isIllegal       = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            opLoad:
            begin
                // Word loads only
                ctrlBits.regWrite  = 1'b1;
                ctrlBits.memRead   = 1'b1;
                ctrlBits.aluSrcImm = 1'b1;
                ctrlBits.wbSel     = wbMem;
                isIllegal          = (funct3 != 3'b010);
            end
            opStore:
            begin
                immValue           = immS;
                ctrlBits.memWrite  = 1'b1;
                ctrlBits.aluSrcImm = 1'b1;
                isIllegal          = (funct3 != 3'b010);
            end
            opImm:
            begin
                ctrlBits.regWrite  = 1'b1;
                ctrlBits.aluSrcImm = 1'b1;
                case (funct3)
                    3'b000: aluOpSel = aluAdd;
                    3'b010: aluOpSel = aluSlt;
                    3'b011: aluOpSel = aluSltu;
                    3'b100: aluOpSel = aluXor;
                    3'b110: aluOpSel = aluOr;
                    3'b111: aluOpSel = aluAnd;
                    3'b001:
                    begin
                        aluOpSel  = aluSll;
                        isIllegal = (funct7 != 7'b0000000);
                    end
                    default:
                    begin
                        // SRLI or SRAI, bit 30 picks arithmetic
                        aluOpSel  = instr[30] ? aluSra : aluSrl;
                        isIllegal = ((funct7 & 7'b1011111) != 7'b0000000);
                    end
                endcase
            end
            opReg:
            begin
                ctrlBits.regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOpSel = instr[30] ? aluSub : aluAdd;
                    3'b001:  aluOpSel = aluSll;
                    3'b010:  aluOpSel = aluSlt;
                    3'b011:  aluOpSel = aluSltu;
                    3'b100:  aluOpSel = aluXor;
                    3'b101:  aluOpSel = instr[30] ? aluSra : aluSrl;
                    3'b110:  aluOpSel = aluOr;
                    default: aluOpSel = aluAnd;
                endcase
                // Bit 30 only valid for SUB and SRA
                isIllegal = ((funct7 & 7'b1011111) != 7'b0000000) ||
                            (instr[30] && (funct3 != 3'b000) && (funct3 != 3'b101));
            end
            default:
            begin
                // FENCE, SYSTEM, zero word and anything unknown
                isIllegal = 1'b1;
            end
        endcase

        // No side effects from an undecoded word
        if (isIllegal)
        begin
            ctrlBits = '0;
        end
    end

    assign dec = '{rd: instr[11:7], rs1: instr[19:15], rs2: instr[24:20], funct3: funct3,
                   imm: immValue, aluOp: aluOpSel, ctrl: ctrlBits, illegal: isIllegal};

endmodule

`default_nettype wire

// File: src/rvCorePkg.sv
// RV32I opcode constants, ALU operation and write-back enums, decode control structs
`default_nettype none

package rvCorePkg;

    // Default PC after reset, overridden from the top level
    localparam logic [31:0] resetVectorDefault = 32'h0000_0000;

    // Major opcodes, bits 6:0 of the instruction word
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    // ALU operations
    // PassB hands the second operand straight through, used by LUI
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10
    } aluOpT;

    // Write-back source select
    // Zero encoding is the ALU so a cleared control word stays harmless
    typedef enum logic [1:0] {
        wbAlu = 2'd0,
        wbMem = 2'd1,
        wbPc4 = 2'd2
    } wbSelT;

    // Control bits produced by the decoder
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;  // Operand B is the immediate
        logic  aluSrcPc;   // Operand A is the PC
        logic  branch;
        logic  jump;       // JAL
        logic  jumpReg;    // JALR
        wbSelT wbSel;
    } ctrlT;

    // Full decode result for one instruction word
    typedef struct packed {
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [31:0] imm;      // Already sign extended
        aluOpT       aluOp;
        ctrlT        ctrl;
        logic        illegal;
    } decodedT;

endpackage

`default_nettype wire
